//--- rtl/div_pkg.sv
package div_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Data types
	////////////////////////////////////////////////////////////////////////////

	// One data word, used for operands, quotient, remainder and APB data
	typedef logic [31:0] word_t;

	// APB byte address
	typedef logic [7:0] addr_t;

	// Holds 0 up to and including the FIFO depth
	typedef logic [3:0] count_t;

	////////////////////////////////////////////////////////////////////////////
	// Divider configuration
	////////////////////////////////////////////////////////////////////////////

	localparam int DIV_XLEN = 32;

	// Bit 31-i set means step i of the restoring divider ends in a register.
	// Registered and combinational steps alternate, so the pipeline has half
	// as many stages as there are quotient bits
	localparam logic [DIV_XLEN-1:0] DIV_STAGE_MASK = 32'hAAAA_AAAA;

	// Number of registered steps selected by a stage mask
	function automatic int count_stages(logic [DIV_XLEN-1:0] mask);
		int n;
		n = 0;
		for (int i = 0; i < DIV_XLEN; i++) begin
			n += int'(mask[i]);
		end
		return n;
	endfunction

	// Core stages plus the registered sign fix-up stage
	localparam int DIV_LATENCY = count_stages(DIV_STAGE_MASK) + 1;

	localparam int FIFO_DEPTH = 8;

	////////////////////////////////////////////////////////////////////////////
	// APB register map
	////////////////////////////////////////////////////////////////////////////

	localparam addr_t ADDR_OPA    = 8'h00;
	localparam addr_t ADDR_OPB    = 8'h04;
	localparam addr_t ADDR_CMD    = 8'h08;
	localparam addr_t ADDR_STATUS = 8'h0C;
	localparam addr_t ADDR_QUO    = 8'h10;
	localparam addr_t ADDR_REM    = 8'h14;

endpackage

//--- rtl/div_apb_regs.sv
`timescale 1ns/1ps

module div_apb_regs (
	input  logic            clk,
	input  logic            rst,
	input  logic            i_psel,
	input  logic            i_penable,
	input  logic            i_pwrite,
	input  div_pkg::addr_t  i_paddr,
	input  div_pkg::word_t  i_pwdata,
	output div_pkg::word_t  o_prdata,
	output logic            o_pready,
	output logic            o_pslverr,
	input  div_pkg::word_t  i_fifo_quo,
	input  div_pkg::word_t  i_fifo_rem,
	input  div_pkg::count_t i_fifo_count,
	input  logic            i_fifo_empty,
	output logic            o_launch,
	output div_pkg::word_t  o_opa,
	output div_pkg::word_t  o_opb,
	output logic            o_signed,
	output logic            o_pop
);

	// Access phase of an APB transfer, there are no wait states
	logic access;
	logic wr_access;
	logic rd_access;

	logic cmd_write;
	logic launch_ok;
	logic credit_free;

	div_pkg::word_t  opa_q;
	div_pkg::word_t  opb_q;
	div_pkg::count_t credits;
	div_pkg::word_t  status;
	div_pkg::word_t  rdata;
	logic            rd_err;

	assign access    = i_psel && i_penable;
	assign wr_access = access && i_pwrite;
	assign rd_access = access && !i_pwrite;

	// A credit stands for one FIFO slot that no division in flight has claimed
	assign credit_free = (credits != '0);
	assign cmd_write   = wr_access && (i_paddr == div_pkg::ADDR_CMD);
	assign launch_ok   = cmd_write && credit_free;

	////////////////////////////////////////////////////////////////////////////
	// Operand registers and launch
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			opa_q <= '0;
			opb_q <= '0;
		end else if (wr_access) begin
			if (i_paddr == div_pkg::ADDR_OPA)
				opa_q <= i_pwdata;
			if (i_paddr == div_pkg::ADDR_OPB)
				opb_q <= i_pwdata;
		end
	end

	// The launch pulse comes one cycle after the CMD access.
	// OPA and OPB cannot change before it, since the next APB access
	// needs its own setup cycle first
	always_ff @(posedge clk) begin
		if (rst) begin
			o_launch <= 1'b0;
			o_signed <= 1'b0;
		end else begin
			o_launch <= launch_ok;
			if (launch_ok)
				o_signed <= i_pwdata[0];
		end
	end

	assign o_opa = opa_q;
	assign o_opb = opb_q;

	// Only a successful REM read removes the head entry
	assign o_pop = rd_access && (i_paddr == div_pkg::ADDR_REM) && !i_fifo_empty;

	////////////////////////////////////////////////////////////////////////////
	// Credit counter
	////////////////////////////////////////////////////////////////////////////

	// Launch and pop never coincide because APB carries one access per cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= div_pkg::count_t'(div_pkg::FIFO_DEPTH);
		end else begin
			case ({launch_ok, o_pop})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read mux and error response
	////////////////////////////////////////////////////////////////////////////

	// Status word, count in bits 3:0 and credit flag in bit 8
	assign status = {23'd0, credit_free, 4'd0, i_fifo_count};

	always_comb begin
		rdata  = '0;
		rd_err = 1'b0;
		case (i_paddr)
			div_pkg::ADDR_OPA:    rdata = opa_q;
			div_pkg::ADDR_OPB:    rdata = opb_q;
			div_pkg::ADDR_STATUS: rdata = status;
			div_pkg::ADDR_QUO: begin
				// Empty FIFO answers zero with an error
				if (i_fifo_empty)
					rd_err = 1'b1;
				else
					rdata = i_fifo_quo;
			end
			div_pkg::ADDR_REM: begin
				if (i_fifo_empty)
					rd_err = 1'b1;
				else
					rdata = i_fifo_rem;
			end
			default: rdata = '0;
		endcase
	end

	assign o_prdata  = rdata;
	assign o_pready  = 1'b1;
	assign o_pslverr = (rd_access && rd_err) || (cmd_write && !credit_free);

	// Pops only follow launches, so credits can never be handed back twice
	a_credit_bound: assert property (@(posedge clk) disable iff (rst)
		credits <= div_pkg::count_t'(div_pkg::FIFO_DEPTH))
		else $error("credit counter above FIFO depth");

endmodule

//--- rtl/div_sign_unit.sv
`timescale 1ns/1ps

module div_sign_unit (
	input  logic           clk,
	input  logic           rst,
	input  logic           i_valid,
	input  logic           i_signed,
	input  div_pkg::word_t i_opa,
	input  div_pkg::word_t i_opb,
	output logic           o_core_valid,
	output div_pkg::word_t o_core_a,
	output div_pkg::word_t o_core_b,
	input  logic           i_core_valid,
	input  div_pkg::word_t i_core_quo,
	input  div_pkg::word_t i_core_rem,
	output logic           o_valid,
	output div_pkg::word_t o_quo,
	output div_pkg::word_t o_rem
);

	logic a_neg;
	logic b_neg;

	// Tag line, one entry per divider step plus the input
	logic tag_vld   [0:div_pkg::DIV_XLEN];
	logic tag_neg_q [0:div_pkg::DIV_XLEN];
	logic tag_neg_r [0:div_pkg::DIV_XLEN];

	////////////////////////////////////////////////////////////////////////////
	// Input side, combinational
	////////////////////////////////////////////////////////////////////////////

	// Unsigned divisions never see a negative operand
	assign a_neg = i_signed && i_opa[div_pkg::DIV_XLEN-1];
	assign b_neg = i_signed && i_opb[div_pkg::DIV_XLEN-1];

	// The most negative value maps onto itself, which is its magnitude unsigned
	assign o_core_valid = i_valid;
	assign o_core_a     = a_neg ? -i_opa : i_opa;
	assign o_core_b     = b_neg ? -i_opb : i_opb;

	always_comb begin
		tag_vld[0]   = i_valid;
		// A zero divisor keeps the all ones quotient untouched
		tag_neg_q[0] = (a_neg ^ b_neg) && (i_opb != '0);
		// Remainder takes the sign of the dividend
		tag_neg_r[0] = a_neg;
	end

	// Tags are registered at the same steps as the core so they stay in step
	for (genvar i = 0; i < div_pkg::DIV_XLEN; i++) begin : gen_tag
		if (div_pkg::DIV_STAGE_MASK[div_pkg::DIV_XLEN-1-i]) begin : gen_reg
			always_ff @(posedge clk) begin
				if (rst)
					tag_vld[i+1] <= 1'b0;
				else
					tag_vld[i+1] <= tag_vld[i];
			end

			always_ff @(posedge clk) begin
				tag_neg_q[i+1] <= tag_neg_q[i];
				tag_neg_r[i+1] <= tag_neg_r[i];
			end
		end else begin : gen_comb
			always_comb begin
				tag_vld[i+1]   = tag_vld[i];
				tag_neg_q[i+1] = tag_neg_q[i];
				tag_neg_r[i+1] = tag_neg_r[i];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output side, registered fix-up
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst)
			o_valid <= 1'b0;
		else
			o_valid <= i_core_valid;
	end

	always_ff @(posedge clk) begin
		o_quo <= tag_neg_q[div_pkg::DIV_XLEN] ? -i_core_quo : i_core_quo;
		o_rem <= tag_neg_r[div_pkg::DIV_XLEN] ? -i_core_rem : i_core_rem;
	end

	// The core and the tag line must agree on the pipeline depth
	a_tag_align: assert property (@(posedge clk) disable iff (rst)
		tag_vld[div_pkg::DIV_XLEN] == i_core_valid)
		else $error("sign tag out of step with core result");

endmodule

//--- rtl/div_pipe_core.sv
`timescale 1ns/1ps

module div_pipe_core (
	input  logic           clk,
	input  logic           rst,
	input  logic           i_valid,
	input  div_pkg::word_t i_a,
	input  div_pkg::word_t i_b,
	output logic           o_valid,
	output div_pkg::word_t o_quo,
	output div_pkg::word_t o_rem
);

	// Step i reads entry i and produces entry i+1.
	// The work word holds the partial remainder in its top i+1 bits and the
	// dividend bits not yet shifted in below it
	logic           vld  [0:div_pkg::DIV_XLEN];
	div_pkg::word_t work [0:div_pkg::DIV_XLEN];
	div_pkg::word_t dvsr [0:div_pkg::DIV_XLEN];
	div_pkg::word_t quo  [0:div_pkg::DIV_XLEN];

	always_comb begin
		vld[0]  = i_valid;
		work[0] = i_a;
		dvsr[0] = i_b;
		quo[0]  = '0;
	end

	////////////////////////////////////////////////////////////////////////////
	// Restoring steps
	////////////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < div_pkg::DIV_XLEN; i++) begin : gen_step
		logic [i:0]     part;
		logic [i:0]     dsub;
		logic           dvsr_wide;
		logic           qbit;
		logic [i:0]     diff;
		div_pkg::word_t low_mask;
		div_pkg::word_t nxt_work;
		div_pkg::word_t nxt_quo;

		// Top i+1 bits are the partial remainder for this step
		assign part = work[i][div_pkg::DIV_XLEN-1 -: i+1];
		assign dsub = dvsr[i][i:0];

		// Divisor with bits above the partial remainder width is always larger
		assign dvsr_wide = |(dvsr[i] >> (i + 1));
		assign qbit      = !dvsr_wide && (part >= dsub);
		assign diff      = qbit ? part - dsub : part;

		// Replace the partial remainder field and keep the dividend tail
		assign low_mask = ~div_pkg::word_t'(0) >> (i + 1);
		assign nxt_work = (work[i] & low_mask)
			| (div_pkg::word_t'(diff) << (div_pkg::DIV_XLEN - 1 - i));
		assign nxt_quo  = quo[i]
			| (div_pkg::word_t'(qbit) << (div_pkg::DIV_XLEN - 1 - i));

		if (div_pkg::DIV_STAGE_MASK[div_pkg::DIV_XLEN-1-i]) begin : gen_reg
			always_ff @(posedge clk) begin
				if (rst)
					vld[i+1] <= 1'b0;
				else
					vld[i+1] <= vld[i];
			end

			always_ff @(posedge clk) begin
				work[i+1] <= nxt_work;
				dvsr[i+1] <= dvsr[i];
				quo[i+1]  <= nxt_quo;
			end
		end else begin : gen_comb
			always_comb begin
				vld[i+1]  = vld[i];
				work[i+1] = nxt_work;
				dvsr[i+1] = dvsr[i];
				quo[i+1]  = nxt_quo;
			end
		end
	end

	// After the last step the whole work word is the remainder
	assign o_valid = vld[div_pkg::DIV_XLEN];
	assign o_quo   = quo[div_pkg::DIV_XLEN];
	assign o_rem   = work[div_pkg::DIV_XLEN];

endmodule

//--- rtl/div_result_fifo.sv
`timescale 1ns/1ps

module div_result_fifo (
	input  logic            clk,
	input  logic            rst,
	input  logic            i_push,
	input  div_pkg::word_t  i_quo,
	input  div_pkg::word_t  i_rem,
	input  logic            i_pop,
	output div_pkg::word_t  o_quo,
	output div_pkg::word_t  o_rem,
	output div_pkg::count_t o_count,
	output logic            o_empty
);

	// Depth is a power of two, so the pointers wrap on their own
	logic [$clog2(div_pkg::FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(div_pkg::FIFO_DEPTH)-1:0] rd_ptr;

	div_pkg::count_t count;
	logic            full;

	div_pkg::word_t quo_mem [div_pkg::FIFO_DEPTH];
	div_pkg::word_t rem_mem [div_pkg::FIFO_DEPTH];

	assign full    = (count == div_pkg::count_t'(div_pkg::FIFO_DEPTH));
	assign o_empty = (count == '0);
	assign o_count = count;

	// Head entry is read without a register
	assign o_quo = quo_mem[rd_ptr];
	assign o_rem = rem_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (i_push) begin
			quo_mem[wr_ptr] <= i_quo;
			rem_mem[wr_ptr] <= i_rem;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (i_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({i_push, i_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// The credit scheme upstream must keep a full FIFO from seeing a push
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		i_push |-> !full)
		else $error("push into full result FIFO");

	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		i_pop |-> !o_empty)
		else $error("pop from empty result FIFO");

endmodule

//--- rtl/apb_divider_top.sv
`timescale 1ns/1ps

module apb_divider_top (
	input  logic           clk,
	input  logic           rst,
	input  logic           i_psel,
	input  logic           i_penable,
	input  logic           i_pwrite,
	input  div_pkg::addr_t i_paddr,
	input  div_pkg::word_t i_pwdata,
	output div_pkg::word_t o_prdata,
	output logic           o_pready,
	output logic           o_pslverr
);

	// Register block to sign unit
	logic           launch;
	logic           launch_signed;
	div_pkg::word_t opa;
	div_pkg::word_t opb;

	// Sign unit and core
	logic           core_in_valid;
	div_pkg::word_t core_a;
	div_pkg::word_t core_b;
	logic           core_out_valid;
	div_pkg::word_t core_quo;
	div_pkg::word_t core_rem;

	// Sign unit to FIFO, and FIFO back to the register block
	logic            res_valid;
	div_pkg::word_t  res_quo;
	div_pkg::word_t  res_rem;
	div_pkg::word_t  fifo_quo;
	div_pkg::word_t  fifo_rem;
	div_pkg::count_t fifo_count;
	logic            fifo_empty;
	logic            fifo_pop;

	div_apb_regs u_regs (
		.clk          (clk),
		.rst          (rst),
		.i_psel       (i_psel),
		.i_penable    (i_penable),
		.i_pwrite     (i_pwrite),
		.i_paddr      (i_paddr),
		.i_pwdata     (i_pwdata),
		.o_prdata     (o_prdata),
		.o_pready     (o_pready),
		.o_pslverr    (o_pslverr),
		.i_fifo_quo   (fifo_quo),
		.i_fifo_rem   (fifo_rem),
		.i_fifo_count (fifo_count),
		.i_fifo_empty (fifo_empty),
		.o_launch     (launch),
		.o_opa        (opa),
		.o_opb        (opb),
		.o_signed     (launch_signed),
		.o_pop        (fifo_pop)
	);

	div_sign_unit u_sign (
		.clk          (clk),
		.rst          (rst),
		.i_valid      (launch),
		.i_signed     (launch_signed),
		.i_opa        (opa),
		.i_opb        (opb),
		.o_core_valid (core_in_valid),
		.o_core_a     (core_a),
		.o_core_b     (core_b),
		.i_core_valid (core_out_valid),
		.i_core_quo   (core_quo),
		.i_core_rem   (core_rem),
		.o_valid      (res_valid),
		.o_quo        (res_quo),
		.o_rem        (res_rem)
	);

	div_pipe_core u_core (
		.clk     (clk),
		.rst     (rst),
		.i_valid (core_in_valid),
		.i_a     (core_a),
		.i_b     (core_b),
		.o_valid (core_out_valid),
		.o_quo   (core_quo),
		.o_rem   (core_rem)
	);

	div_result_fifo u_fifo (
		.clk     (clk),
		.rst     (rst),
		.i_push  (res_valid),
		.i_quo   (res_quo),
		.i_rem   (res_rem),
		.i_pop   (fifo_pop),
		.o_quo   (fifo_quo),
		.o_rem   (fifo_rem),
		.o_count (fifo_count),
		.o_empty (fifo_empty)
	);

endmodule

//--- testbench/tb_apb_divider.sv
`timescale 1ns/1ps

module tb_apb_divider;

	localparam int CLK_NS     = 8;
	localparam int NUM_RANDOM = 200;
	// Random, corner, pipeline and back-pressure launches together
	localparam int NUM_LAUNCHES = NUM_RANDOM + 7 + 2 * div_pkg::FIFO_DEPTH + 2;
	localparam int WATCHDOG_NS  = NUM_LAUNCHES * (div_pkg::DIV_LATENCY + 20) * CLK_NS + 40000;
	// Each STATUS poll takes three clocks, so this covers the latency many times
	localparam int POLL_LIMIT   = div_pkg::DIV_LATENCY + 20;

	logic           clk;
	logic           rst;
	logic           psel;
	logic           penable;
	logic           pwrite;
	div_pkg::addr_t paddr;
	div_pkg::word_t pwdata;
	div_pkg::word_t prdata;
	logic           pready;
	logic           pslverr;

	integer seed;
	int     errors;
	int     checks;
	// Expected {quotient, remainder} pairs in launch order
	logic [63:0] expected_q [$];

	apb_divider_top i_apb_divider_top (
		.clk       (clk),
		.rst       (rst),
		.i_psel    (psel),
		.i_penable (penable),
		.i_pwrite  (pwrite),
		.i_paddr   (paddr),
		.i_pwdata  (pwdata),
		.o_prdata  (prdata),
		.o_pready  (pready),
		.o_pslverr (pslverr)
	);

	always #(CLK_NS / 2) clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// APB transfers
	////////////////////////////////////////////////////////////////////////////

	// The slave has no wait states, so every access phase must see PREADY high
	task automatic check_ready();
		checks++;
		assert (pready === 1'b1) else begin
			$display("FAIL %0t ns: PREADY is %b in the access phase", $time, pready);
			errors++;
		end
	endtask

	// Setup on one falling edge and access on the next, with outputs sampled mid-phase
	task automatic apb_write(input div_pkg::addr_t addr, input div_pkg::word_t data,
		output logic err);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(negedge clk);
		penable = 1'b1;
		#2;
		err = pslverr;
		check_ready();
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_read(input div_pkg::addr_t addr, output div_pkg::word_t data,
		output logic err);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(negedge clk);
		penable = 1'b1;
		#2;
		data = prdata;
		err  = pslverr;
		check_ready();
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model and stimulus
	////////////////////////////////////////////////////////////////////////////

	// RISC-V rules with the zero divisor and signed overflow cases spelled out
	function automatic logic [63:0] model_div(input div_pkg::word_t a,
		input div_pkg::word_t b, input logic sgn);
		div_pkg::word_t q;
		div_pkg::word_t r;
		if (b == '0) begin
			q = '1;
			r = a;
		end else if (sgn && a == 32'h8000_0000 && b == 32'hFFFF_FFFF) begin
			q = a;
			r = '0;
		end else if (sgn) begin
			q = $signed(a) / $signed(b);
			r = $signed(a) % $signed(b);
		end else begin
			q = a / b;
			r = a % b;
		end
		return {q, r};
	endfunction

	// Biased toward zero, minus one, the most negative value and small numbers
	function automatic div_pkg::word_t rand_operand();
		int             pick;
		div_pkg::word_t val;
		pick = $random(seed) & 7;
		case (pick)
			0:       val = '0;
			1:       val = '1;
			2:       val = 32'h8000_0000;
			3:       val = $random(seed) & 32'hF;
			4:       val = -($random(seed) & 32'hF);
			default: val = $random(seed);
		endcase
		return val;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string what, input div_pkg::word_t got,
		input div_pkg::word_t exp);
		checks++;
		assert (got === exp) else begin
			$display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		errors++;
	endtask

	// Poll STATUS until the FIFO holds the wanted number of results
	task automatic wait_count(input int target);
		div_pkg::word_t st;
		logic           e;
		int             polls;
		polls = 0;
		apb_read(div_pkg::ADDR_STATUS, st, e);
		while (int'(st[3:0]) != target && polls < POLL_LIMIT) begin
			apb_read(div_pkg::ADDR_STATUS, st, e);
			polls++;
		end
		if (int'(st[3:0]) != target)
			report_problem($sformatf("FIFO count stuck at %0d while waiting for %0d",
				st[3:0], target));
	endtask

	// Operands go first and the command last, and the model keeps only accepted launches
	task automatic launch(input div_pkg::word_t a, input div_pkg::word_t b,
		input logic sgn, output logic err);
		logic e;
		apb_write(div_pkg::ADDR_OPA, a, e);
		apb_write(div_pkg::ADDR_OPB, b, e);
		apb_write(div_pkg::ADDR_CMD, {31'd0, sgn}, err);
		if (!err)
			expected_q.push_back(model_div(a, b, sgn));
	endtask

	task automatic random_launch(output logic err);
		div_pkg::word_t a;
		div_pkg::word_t b;
		logic           sgn;
		a   = rand_operand();
		b   = rand_operand();
		sgn = $random(seed) & 1;
		launch(a, b, sgn, err);
	endtask

	// Read QUO then REM, which pops the head, and compare with the model
	task automatic pop_and_check();
		div_pkg::word_t q;
		div_pkg::word_t r;
		logic           eq;
		logic           er;
		logic [63:0]    exp;
		if (expected_q.size() == 0) begin
			report_problem("tried to read a result but no launch is outstanding");
		end else begin
			exp = expected_q.pop_front();
			apb_read(div_pkg::ADDR_QUO, q, eq);
			apb_read(div_pkg::ADDR_REM, r, er);
			check_value("QUO read error flag", div_pkg::word_t'(eq), '0);
			check_value("REM read error flag", div_pkg::word_t'(er), '0);
			check_value("quotient", q, exp[63:32]);
			check_value("remainder", r, exp[31:0]);
		end
	endtask

	// One division from launch to result
	task automatic run_single(input div_pkg::word_t a, input div_pkg::word_t b,
		input logic sgn);
		logic err;
		launch(a, b, sgn, err);
		check_value("CMD write error flag", div_pkg::word_t'(err), '0);
		wait_count(1);
		pop_and_check();
	endtask

	task automatic report_test(input string name, input int start_errors);
		$display("Test %s done, %0d errors", name, errors - start_errors);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic           err;
		logic           e;
		div_pkg::word_t st;
		div_pkg::word_t a;
		div_pkg::word_t b;
		logic           sgn;
		int             start;

		seed    = 32'h9b32;
		errors  = 0;
		checks  = 0;
		clk     = 1'b0;
		rst     = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Random single divisions in both modes
		start = errors;
		for (int i = 0; i < NUM_RANDOM; i++) begin
			a   = rand_operand();
			b   = rand_operand();
			sgn = $random(seed) & 1;
			run_single(a, b, sgn);
		end
		report_test("single operations", start);

		// Zero divisors, signed overflow and mixed signs
		start = errors;
		run_single(32'h1234_5678, 32'h0, 1'b0);
		run_single(32'hDEAD_BEEF, 32'h0, 1'b1);
		run_single(32'h8000_0000, 32'hFFFF_FFFF, 1'b1);
		run_single(32'h8000_0000, 32'hFFFF_FFFF, 1'b0);
		run_single(32'hFFFF_FFF9, 32'h2, 1'b1);
		run_single(32'h7, 32'hFFFF_FFFE, 1'b1);
		run_single(32'hFFFF_FFF9, 32'hFFFF_FFFE, 1'b1);
		report_test("corner cases", start);

		// A full FIFO worth of divisions in flight at once
		start = errors;
		for (int i = 0; i < div_pkg::FIFO_DEPTH; i++) begin
			random_launch(err);
			check_value("CMD error flag in burst", div_pkg::word_t'(err), '0);
		end
		wait_count(div_pkg::FIFO_DEPTH);
		repeat (div_pkg::FIFO_DEPTH) pop_and_check();
		report_test("pipelining", start);

		// Credits run out and one pop frees exactly one launch
		start = errors;
		for (int i = 0; i < div_pkg::FIFO_DEPTH; i++) begin
			random_launch(err);
			check_value("CMD error flag with credit free", div_pkg::word_t'(err), '0);
		end
		random_launch(err);
		check_value("CMD error flag with no credit", div_pkg::word_t'(err), 32'd1);
		wait_count(div_pkg::FIFO_DEPTH);
		pop_and_check();
		random_launch(err);
		check_value("CMD error flag after a pop", div_pkg::word_t'(err), '0);
		wait_count(div_pkg::FIFO_DEPTH);
		// Count equals accepted launches and the credit bit is clear
		apb_read(div_pkg::ADDR_STATUS, st, e);
		check_value("STATUS with FIFO full", st, div_pkg::word_t'(div_pkg::FIFO_DEPTH));
		repeat (div_pkg::FIFO_DEPTH) pop_and_check();
		report_test("back-pressure", start);

		// A fresh reset followed by result reads on an empty FIFO
		start = errors;
		@(negedge clk);
		rst = 1'b1;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		if (expected_q.size() != 0)
			report_problem("model still holds results that were never read");
		apb_read(div_pkg::ADDR_STATUS, st, e);
		check_value("STATUS after reset", st, 32'h0000_0100);
		apb_read(div_pkg::ADDR_QUO, st, e);
		check_value("QUO data on empty FIFO", st, '0);
		check_value("QUO error flag on empty FIFO", div_pkg::word_t'(e), 32'd1);
		apb_read(div_pkg::ADDR_REM, st, e);
		check_value("REM data on empty FIFO", st, '0);
		check_value("REM error flag on empty FIFO", div_pkg::word_t'(e), 32'd1);
		apb_read(div_pkg::ADDR_STATUS, st, e);
		check_value("STATUS after empty reads", st, 32'h0000_0100);
		report_test("empty reads", start);

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// Stops a run that no longer makes progress
	initial begin
		#(WATCHDOG_NS);
		$display("Run stopped by the watchdog after %0d ns without finishing", WATCHDOG_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- apb_divider.f
rtl/div_pkg.sv
rtl/div_apb_regs.sv
rtl/div_sign_unit.sv
rtl/div_pipe_core.sv
rtl/div_result_fifo.sv
rtl/apb_divider_top.sv
testbench/tb_apb_divider.sv
